// File: source/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

  // bus widths
  parameter int addr_w = 64;
  parameter int data_w = 32;
  parameter int msg_w = 8;

  // bit 31 of a ring index marks an active core
  parameter int active_bit = 31;

  // thread header sits in front of the code at the start address
  parameter int thread_header_space_default = 16;

  // core FSM states, as seen from the bridge
  typedef enum logic [4:0] {
    wait_for_start,
    start_begin,
    start_read_cmd,
    start_read_cmd_p,
    read_cond,
    read_cond_p,
    read_src1,
    read_src1_p,
    read_src0,
    read_src0_p,
    read_dst,
    write_reg_ip,
    write_dst,
    write_dst_p,
    write_src1,
    write_src0,
    write_cond,
    alu_begin,
    finish_begin,
    finish_end,
    idle
  } cpu_state_t;

  // ring messages, msg_none is zero so outputs can be OR-ed
  typedef enum logic [msg_w-1:0] {
    msg_none,
    msg_reset,
    msg_start,
    msg_end
  } cpu_msg_t;

  // ring index compared with own index
  typedef enum logic [1:0] {
    rel_none,
    rel_lower,
    rel_higher,
    rel_same
  } cpu_rel_t;

  // states that fetch operands over the ring
  function automatic logic is_read_state(cpu_state_t s);
    return s inside {start_read_cmd, start_read_cmd_p, read_cond, read_cond_p,
                     read_src1, read_src1_p, read_src0, read_src0_p, read_dst};
  endfunction

  // states that store results over the ring
  function automatic logic is_write_state(cpu_state_t s);
    return s inside {write_reg_ip, write_dst, write_dst_p, write_src1,
                     write_src0, write_cond};
  endfunction

endpackage

`default_nettype wire

// File: source/reset_sequencer.sv
`default_nettype none

module reset_sequencer (
  input  wire                   clk,
  input  wire                   ext_rst_b,
  input  bridge_pkg::cpu_state_t state,
  input  wire                   retire,
  output logic                  running,
  output logic                  index_load,
  output logic                  rst,
  output logic                  ext_rst_e,
  output logic                  ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t  seq_msg
);
  import bridge_pkg::*;

  // phase numbers, done means the bridge is running
  localparam logic [2:0] ph_clear = 3'd0;
  localparam logic [2:0] ph_check = 3'd1;
  localparam logic [2:0] ph_load = 3'd2;
  localparam logic [2:0] ph_pulse = 3'd3;
  localparam logic [2:0] ph_online = 3'd4;
  localparam logic [2:0] ph_done = 3'd5;

  logic [2:0] phase;

  assign running = (phase == ph_done);
  // tracker samples the ring index on the edge leaving phase 2
  assign index_load = (phase == ph_load);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      phase <= ph_clear;
      rst <= 1'b0;
      ext_rst_e <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      seq_msg <= msg_none;
    end else begin
      case (phase)
        ph_clear: begin
          ext_dispatcher_q <= 1'b0;
          phase <= ph_check;
        end
        ph_check: begin
          // finished thread keeps no index, so skip the load
          phase <= (state == finish_end) ? ph_pulse : ph_load;
        end
        ph_load: begin
          seq_msg <= msg_reset;
          phase <= ph_pulse;
        end
        ph_pulse: begin
          seq_msg <= msg_none;
          rst <= 1'b1;
          // core reset only goes out on a fresh start
          ext_rst_e <= (state != finish_end);
          phase <= ph_online;
        end
        ph_online: begin
          ext_dispatcher_q <= 1'b1;
          rst <= 1'b0;
          ext_rst_e <= 1'b0;
          phase <= ph_done;
        end
        default: begin
          // thread end restarts the whole sequence
          if (retire) begin
            ext_dispatcher_q <= 1'b0;
            phase <= ph_clear;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/cpu_index_tracker.sv
`default_nettype none

module cpu_index_tracker #(
  parameter int DATA_W = bridge_pkg::data_w
) (
  input  wire                   clk,
  input  wire                   ext_rst_b,
  input  wire                   running,
  input  wire                   index_load,
  input  wire                   retire,
  input  wire                   ext_next_cpu_q,
  input  wire                   ext_next_cpu_e,
  input  bridge_pkg::cpu_state_t state,
  input  wire [DATA_W-1:0]      ext_cpu_index_in,
  input  bridge_pkg::cpu_msg_t  ext_cpu_msg_in,
  output logic [DATA_W-1:0]     cpu_index,
  output bridge_pkg::cpu_rel_t  cpu_ind_rel
);
  import bridge_pkg::*;

  localparam logic [DATA_W-1:0] active_flag = DATA_W'(1) << active_bit;

  logic [DATA_W-1:0] next_index;
  logic              ring_active;
  logic              own_active;
  logic              ring_lower;
  logic              ring_higher;
  logic              ring_same;
  logic              granted;

  // position compare ignores the active flag
  assign ring_active = ext_cpu_index_in[active_bit];
  assign own_active = cpu_index[active_bit];
  assign ring_lower = ext_cpu_index_in[active_bit-1:0] < cpu_index[active_bit-1:0];
  assign ring_higher = ext_cpu_index_in[active_bit-1:0] > cpu_index[active_bit-1:0];
  assign ring_same = (ext_cpu_index_in == cpu_index);
  assign granted = ext_next_cpu_q && (cpu_ind_rel == rel_same);

  // renumbering from START and END seen on the ring
  always_comb begin
    next_index = cpu_index;
    if (ring_same) begin
      // first core to start takes position 0
      if (cpu_index == '0 && state == start_begin) begin
        next_index = active_flag;
      end
    end else if (ring_active && ext_cpu_msg_in == msg_end && own_active && ring_lower) begin
      // a lower core finished, move down
      next_index[active_bit-1:0] = cpu_index[active_bit-1:0] - 1'b1;
    end else if (!ring_active && ext_cpu_msg_in == msg_start) begin
      if (own_active) begin
        next_index[active_bit-1:0] = cpu_index[active_bit-1:0] + 1'b1;
      end else begin
        next_index[active_bit-1:0] = cpu_index[active_bit-1:0] - 1'b1;
      end
    end
    // waiting core marks itself active
    if (state == start_begin && !granted) begin
      next_index[active_bit] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      cpu_index <= '0;
      cpu_ind_rel <= rel_none;
    end else begin
      if (index_load) begin
        cpu_index <= ext_cpu_index_in;
      end else if (retire) begin
        cpu_index <= '0;
      end else if (running) begin
        cpu_index <= next_index;
      end

      // relation is registered, grant uses it a cycle later
      if (running) begin
        if (ext_next_cpu_q) begin
          if (ring_lower) begin
            cpu_ind_rel <= rel_lower;
          end else if (ring_higher) begin
            cpu_ind_rel <= rel_higher;
          end else if (ring_same) begin
            cpu_ind_rel <= rel_same;
          end
        end else if (ext_next_cpu_e) begin
          // token passed on
          cpu_ind_rel <= rel_none;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/token_dispatch.sv
`default_nettype none

module token_dispatch #(
  parameter int ADDR_W = bridge_pkg::addr_w,
  parameter int DATA_W = bridge_pkg::data_w,
  parameter int THREAD_HEADER_SPACE = bridge_pkg::thread_header_space_default
) (
  input  wire                   clk,
  input  wire                   ext_rst_b,
  input  wire                   running,
  input  wire                   bus_busy,
  input  wire                   ext_next_cpu_q,
  input  wire                   read_q,
  input  wire                   write_q,
  input  bridge_pkg::cpu_state_t state,
  input  bridge_pkg::cpu_rel_t  cpu_ind_rel,
  input  wire [ADDR_W-1:0]      addr_in,
  input  wire [DATA_W-1:0]      data_in,
  output logic                  disp_online,
  output logic                  ext_next_cpu_e,
  output logic                  next_state,
  output logic                  disp_index_en,
  output logic                  run_dispatcher_q,
  output logic                  retire,
  output bridge_pkg::cpu_msg_t  disp_msg,
  output logic [ADDR_W-1:0]     base_addr,
  output logic [ADDR_W-1:0]     base_addr_data
);
  import bridge_pkg::*;

  logic granted;
  logic rw_class;

  // token is ours when the registered relation says same index
  assign granted = ext_next_cpu_q && (cpu_ind_rel == rel_same);
  assign rw_class = is_read_state(state) || is_write_state(state);

  // base addresses, loaded only on a start grant
  always_ff @(posedge clk) begin
    if (running && !bus_busy && granted && state == wait_for_start) begin
      base_addr <= addr_in + ADDR_W'(THREAD_HEADER_SPACE);
      base_addr_data <= ADDR_W'(data_in);
    end
  end

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      disp_online <= 1'b0;
      ext_next_cpu_e <= 1'b0;
      next_state <= 1'b0;
      disp_index_en <= 1'b0;
      run_dispatcher_q <= 1'b0;
      retire <= 1'b0;
      disp_msg <= msg_none;
    end else begin
      // single-cycle outputs
      next_state <= 1'b0;
      disp_index_en <= 1'b0;
      retire <= 1'b0;
      disp_msg <= msg_none;

      if (!running) begin
        // sequence in progress, dispatcher offline
        disp_online <= 1'b0;
        ext_next_cpu_e <= 1'b0;
        run_dispatcher_q <= 1'b0;
      end else if (!bus_busy) begin
        if (disp_online) begin
          if (read_q || write_q) begin
            ext_next_cpu_e <= 1'b1;
          end else if (ext_next_cpu_e) begin
            // request done, hand the token on
            ext_next_cpu_e <= 1'b0;
            disp_online <= 1'b0;
          end
        end

        if (granted) begin
          disp_online <= 1'b1;
          case (state)
            wait_for_start: begin
              disp_msg <= msg_start;
              disp_index_en <= 1'b1;
              ext_next_cpu_e <= 1'b1;
              next_state <= 1'b1;
            end
            finish_begin: begin
              disp_msg <= msg_end;
              disp_index_en <= 1'b1;
              ext_next_cpu_e <= 1'b1;
              next_state <= 1'b1;
            end
            default: begin
              if (rw_class) begin
                run_dispatcher_q <= 1'b1;
              end
            end
          endcase
        end else begin
          if (state == finish_end) begin
            // one pulse, the sequencer leaves running right after
            retire <= !retire;
          end else if (!rw_class && state != start_begin) begin
            // dispatcher line held through the read and write states
            run_dispatcher_q <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ring_bus_drive.sv
`default_nettype none

module ring_bus_drive #(
  parameter int DATA_W = bridge_pkg::data_w
) (
  input  wire                   read_q,
  input  wire                   write_q,
  input  wire                   disp_online,
  input  wire                   disp_index_en,
  input  wire                   running,
  input  wire                   seq_dispatcher_q,
  input  wire                   run_dispatcher_q,
  input  bridge_pkg::cpu_state_t state,
  input  bridge_pkg::cpu_msg_t  seq_msg,
  input  bridge_pkg::cpu_msg_t  disp_msg,
  input  wire [DATA_W-1:0]      cpu_index,
  output logic                  ext_read_q,
  output logic                  ext_read_en,
  output logic                  ext_write_q,
  output logic                  ext_write_en,
  output logic                  ext_cpu_index_en,
  output logic                  ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t  ext_cpu_msg,
  output logic [DATA_W-1:0]     ext_cpu_index_out
);
  import bridge_pkg::*;

  // requests reach the ring only while we hold the token
  assign ext_read_en = is_read_state(state) && disp_online;
  assign ext_write_en = is_write_state(state) && disp_online;
  assign ext_read_q = read_q && ext_read_en;
  assign ext_write_q = write_q && ext_write_en;

  // only one source is non-zero at a time
  assign ext_cpu_msg = cpu_msg_t'(seq_msg | disp_msg);

  // index goes out with start and end messages
  assign ext_cpu_index_out = cpu_index;
  assign ext_cpu_index_en = disp_index_en;

  // sequencer owns the line until running
  assign ext_dispatcher_q = running ? run_dispatcher_q : seq_dispatcher_q;

endmodule

`default_nettype wire

// File: source/bridge_to_outside.sv
`default_nettype none

module bridge_to_outside #(
  parameter int ADDR_W = bridge_pkg::addr_w,
  parameter int DATA_W = bridge_pkg::data_w,
  parameter int THREAD_HEADER_SPACE = bridge_pkg::thread_header_space_default
) (
  input  wire                   clk,
  input  wire                   ext_rst_b,
  input  bridge_pkg::cpu_state_t state,
  input  wire                   bus_busy,
  input  wire [ADDR_W-1:0]      addr_in,
  input  wire [DATA_W-1:0]      data_in,
  input  wire                   read_q,
  input  wire                   write_q,
  input  wire                   ext_next_cpu_q,
  input  wire [DATA_W-1:0]      ext_cpu_index_in,
  input  bridge_pkg::cpu_msg_t  ext_cpu_msg_in,
  output logic [ADDR_W-1:0]     base_addr,
  output logic [ADDR_W-1:0]     base_addr_data,
  output bridge_pkg::cpu_rel_t  cpu_ind_rel,
  output logic                  disp_online,
  output logic                  next_state,
  output logic                  rst,
  output logic                  ext_rst_e,
  output logic                  ext_next_cpu_e,
  output logic                  ext_dispatcher_q,
  output bridge_pkg::cpu_msg_t  ext_cpu_msg,
  output logic [DATA_W-1:0]     ext_cpu_index_out,
  output logic                  ext_cpu_index_en,
  output logic                  ext_read_q,
  output logic                  ext_read_en,
  output logic                  ext_write_q,
  output logic                  ext_write_en
);
  import bridge_pkg::*;

  logic              running;
  logic              index_load;
  logic              retire;
  logic              seq_dispatcher_q;
  logic              run_dispatcher_q;
  logic              disp_index_en;
  cpu_msg_t          seq_msg;
  cpu_msg_t          disp_msg;
  logic [DATA_W-1:0] cpu_index;

  reset_sequencer u_seq (
    .clk(clk), .ext_rst_b(ext_rst_b), .state(state), .retire(retire),
    .running(running), .index_load(index_load), .rst(rst),
    .ext_rst_e(ext_rst_e), .ext_dispatcher_q(seq_dispatcher_q), .seq_msg(seq_msg)
  );

  cpu_index_tracker #(.DATA_W(DATA_W)) u_index (
    .clk(clk), .ext_rst_b(ext_rst_b), .running(running),
    .index_load(index_load), .retire(retire), .ext_next_cpu_q(ext_next_cpu_q),
    .ext_next_cpu_e(ext_next_cpu_e), .state(state),
    .ext_cpu_index_in(ext_cpu_index_in), .ext_cpu_msg_in(ext_cpu_msg_in),
    .cpu_index(cpu_index), .cpu_ind_rel(cpu_ind_rel)
  );

  token_dispatch #(
    .ADDR_W(ADDR_W), .DATA_W(DATA_W), .THREAD_HEADER_SPACE(THREAD_HEADER_SPACE)
  ) u_disp (
    .clk(clk), .ext_rst_b(ext_rst_b), .running(running), .bus_busy(bus_busy),
    .ext_next_cpu_q(ext_next_cpu_q), .read_q(read_q), .write_q(write_q),
    .state(state), .cpu_ind_rel(cpu_ind_rel), .addr_in(addr_in), .data_in(data_in),
    .disp_online(disp_online), .ext_next_cpu_e(ext_next_cpu_e),
    .next_state(next_state), .disp_index_en(disp_index_en),
    .run_dispatcher_q(run_dispatcher_q), .retire(retire), .disp_msg(disp_msg),
    .base_addr(base_addr), .base_addr_data(base_addr_data)
  );

  ring_bus_drive #(.DATA_W(DATA_W)) u_drive (
    .read_q(read_q), .write_q(write_q), .disp_online(disp_online),
    .disp_index_en(disp_index_en), .running(running),
    .seq_dispatcher_q(seq_dispatcher_q), .run_dispatcher_q(run_dispatcher_q),
    .state(state), .seq_msg(seq_msg), .disp_msg(disp_msg), .cpu_index(cpu_index),
    .ext_read_q(ext_read_q), .ext_read_en(ext_read_en), .ext_write_q(ext_write_q),
    .ext_write_en(ext_write_en), .ext_cpu_index_en(ext_cpu_index_en),
    .ext_dispatcher_q(ext_dispatcher_q), .ext_cpu_msg(ext_cpu_msg),
    .ext_cpu_index_out(ext_cpu_index_out)
  );

endmodule

`default_nettype wire

// File: tests/bridge_tests.svh
`ifndef BRIDGE_TESTS_SVH
`define BRIDGE_TESTS_SVH

// 8 cycles of reset, then release, edges counted from the release
task automatic assert_reset(input logic [31:0] load_index);
  @(posedge clk);
  ext_rst_b <= 1'b1;
  state <= idle;
  bus_busy <= 1'b0;
  read_q <= 1'b0;
  write_q <= 1'b0;
  ext_next_cpu_q <= 1'b0;
  ext_cpu_msg_in <= msg_none;
  ext_cpu_index_in <= load_index;
  repeat (7) begin
    @(posedge clk);
  end
  @(negedge clk);
  if (rst !== 1'b0 || ext_rst_e !== 1'b0 || next_state !== 1'b0 || ext_next_cpu_e !== 1'b0) begin
    log_mismatch("control outputs not low during reset");
  end
  if (disp_online !== 1'b0 || ext_cpu_msg !== msg_none || cpu_ind_rel !== rel_none) begin
    log_mismatch("dispatcher or relation not cleared during reset");
  end
  if (ext_read_en !== 1'b0 || ext_write_en !== 1'b0 || ext_cpu_index_en !== 1'b0) begin
    log_mismatch("ring enables not low during reset");
  end
  @(posedge clk);
  ext_rst_b <= 1'b0;
endtask

// rst pulse marks the end of the sequence
task automatic wait_rst_pulse(input int max_cycles);
  int n;
  n = 0;
  @(negedge clk);
  while (rst !== 1'b1 && n < max_cycles) begin
    @(negedge clk);
    n++;
  end
  if (rst !== 1'b1) begin
    log_problem("timeout waiting for the rst pulse");
  end else begin
    @(negedge clk);
    if (rst !== 1'b0) begin
      log_mismatch("rst high for more than one cycle");
    end
  end
endtask

task automatic bring_up(input logic [31:0] load_index);
  assert_reset(load_index);
  wait_rst_pulse(20);
endtask

// one cycle in start_begin sets the active flag
task automatic activate(input logic [31:0] exp_index);
  @(posedge clk);
  state <= start_begin;
  @(posedge clk);
  state <= wait_for_start;
  @(negedge clk);
  if (ext_cpu_index_out !== exp_index) begin
    log_mismatch($sformatf("index %h after start_begin, expected %h", ext_cpu_index_out,
                           exp_index));
  end
endtask

// ring offers the token, relation registers first, grant one edge later
task automatic present_token(input logic [31:0] ring_index);
  @(posedge clk);
  ext_cpu_index_in <= ring_index;
  ext_next_cpu_q <= 1'b1;
  @(negedge clk);
  @(posedge clk);
  @(negedge clk);
  if (cpu_ind_rel !== rel_same) begin
    log_mismatch($sformatf("relation %0d for ring index %h", cpu_ind_rel, ring_index));
  end
  if (ext_cpu_msg !== msg_none) begin
    log_mismatch("message before the relation was registered");
  end
  @(posedge clk);
  ext_next_cpu_q <= 1'b0;
  @(negedge clk);
endtask

// start or end message carrying the index, plus next_state
task automatic expect_message(input cpu_msg_t exp_msg, input logic [31:0] exp_index);
  if (ext_cpu_msg !== exp_msg || ext_cpu_index_en !== 1'b1) begin
    log_mismatch($sformatf("ring message %0d, expected %0d", ext_cpu_msg, exp_msg));
  end
  if (ext_cpu_index_out !== exp_index) begin
    log_mismatch($sformatf("carried index %h, expected %h", ext_cpu_index_out, exp_index));
  end
  if (next_state !== 1'b1 || ext_next_cpu_e !== 1'b1 || disp_online !== 1'b1) begin
    log_mismatch("next_state, ext_next_cpu_e or disp_online missing on the grant");
  end
endtask

// read or write round: grant, mirror the request, token handed on
task automatic forward_once(input cpu_state_t st, input logic wr, input logic [31:0] idx);
  @(posedge clk);
  state <= st;
  @(negedge clk);
  if (ext_read_en !== 1'b0 || ext_write_en !== 1'b0) begin
    log_mismatch("request enable high without the token");
  end
  // state already seen by the DUT, no grant yet
  @(posedge clk);
  @(negedge clk);
  if (ext_dispatcher_q !== 1'b0) begin
    log_mismatch("dispatcher line up before the grant");
  end
  present_token(idx);
  if (disp_online !== 1'b1 || ext_dispatcher_q !== 1'b1 || ext_cpu_msg !== msg_none) begin
    log_mismatch("read/write grant did not bring the dispatcher online");
  end
  if (ext_read_en !== !wr || ext_write_en !== wr) begin
    log_mismatch("wrong request enable after the grant");
  end
  @(posedge clk);
  read_q <= !wr;
  write_q <= wr;
  @(negedge clk);
  if (ext_read_q !== !wr || ext_write_q !== wr) begin
    log_mismatch("request not mirrored onto the ring");
  end
  @(posedge clk);
  read_q <= 1'b0;
  write_q <= 1'b0;
  @(negedge clk);
  if (ext_next_cpu_e !== 1'b1 || ext_read_q !== 1'b0 || ext_write_q !== 1'b0) begin
    log_mismatch("ext_next_cpu_e not raised by the request");
  end
  @(posedge clk);
  @(negedge clk);
  if (disp_online !== 1'b0 || ext_read_en !== 1'b0 || ext_write_en !== 1'b0) begin
    log_mismatch("dispatcher still online after the request");
  end
  // leave the read/write states so the dispatcher line drops
  @(posedge clk);
  state <= idle;
endtask

task automatic reset_order();
  logic [31:0] load_index;
  cpu_msg_t    exp_msg;
  logic        exp_rst;
  int          k;
  load_index = {1'b0, random_position()};
  assert_reset(load_index);
  for (k = 1; k <= 5; k++) begin
    @(posedge clk);
    @(negedge clk);
    exp_msg = (k == 3) ? msg_reset : msg_none;
    exp_rst = (k == 4);
    if (ext_cpu_msg !== exp_msg) begin
      log_mismatch($sformatf("edge %0d: ring message %0d", k, ext_cpu_msg));
    end
    if (rst !== exp_rst || ext_rst_e !== exp_rst) begin
      log_mismatch($sformatf("edge %0d: rst %b ext_rst_e %b", k, rst, ext_rst_e));
    end
    // sequencer side of the dispatcher line, before the dispatcher takes it over
    if (dut0.u_seq.ext_dispatcher_q !== (k == 5)) begin
      log_mismatch($sformatf("edge %0d: sequencer dispatcher line wrong", k));
    end
    if (k >= 3 && ext_cpu_index_out !== load_index) begin
      log_mismatch($sformatf("edge %0d: index %h not loaded", k, ext_cpu_index_out));
    end
  end
endtask

task automatic thread_start();
  logic [30:0]          pos;
  logic [addr_bits-1:0] addr;
  logic [data_bits-1:0] data;
  pos = random_position();
  addr = {$random(seed), $random(seed)};
  data = $random(seed);
  bring_up({1'b0, pos});
  activate({1'b1, pos});
  @(posedge clk);
  addr_in <= addr;
  data_in <= data;
  present_token({1'b1, pos});
  expect_message(msg_start, {1'b1, pos});
  if (base_addr !== addr + addr_bits'(header_space) || base_addr_data !== {32'h0, data}) begin
    log_mismatch($sformatf("base %h data base %h after start", base_addr, base_addr_data));
  end
  @(posedge clk);
  @(negedge clk);
  if (next_state !== 1'b0 || ext_cpu_msg !== msg_none) begin
    log_mismatch("next_state or msg_start longer than one cycle");
  end
endtask

task automatic request_forwarding();
  logic [30:0] pos;
  pos = random_position();
  bring_up({1'b0, pos});
  forward_once(read_src1, 1'b0, {1'b0, pos});
  forward_once(write_dst, 1'b1, {1'b0, pos});
endtask

task automatic index_renumbering();
  logic [30:0] pos;
  pos = random_position();
  bring_up({1'b0, pos});
  activate({1'b1, pos});
  // an inactive core announces START, so we move up one place
  @(posedge clk);
  ext_cpu_index_in <= {1'b0, random_position()};
  ext_cpu_msg_in <= msg_start;
  @(posedge clk);
  ext_cpu_msg_in <= msg_none;
  present_token({1'b1, pos + 31'd1});
  expect_message(msg_start, {1'b1, pos + 31'd1});
  // active core at position 1 ends, we move back down
  @(posedge clk);
  ext_cpu_index_in <= {1'b1, 31'd1};
  ext_cpu_msg_in <= msg_end;
  state <= finish_begin;
  @(posedge clk);
  ext_cpu_msg_in <= msg_none;
  present_token({1'b1, pos});
  expect_message(msg_end, {1'b1, pos});
endtask

task automatic thread_end();
  logic [30:0] pos;
  int          n;
  logic        seen;
  pos = random_position();
  bring_up({1'b0, pos});
  activate({1'b1, pos});
  @(posedge clk);
  state <= finish_begin;
  present_token({1'b1, pos});
  expect_message(msg_end, {1'b1, pos});
  @(posedge clk);
  state <= finish_end;
  n = 0;
  seen = 1'b0;
  // restart skips the index load, so no msg_reset and no core reset
  while (!seen && n < 20) begin
    @(negedge clk);
    n++;
    if (ext_cpu_msg !== msg_none && n > 1) begin
      log_mismatch("ring message during the restart");
    end
    if (rst === 1'b1) begin
      seen = 1'b1;
      if (ext_rst_e !== 1'b0) begin
        log_mismatch("ext_rst_e raised on the restart after finish_end");
      end
    end
  end
  if (!seen) begin
    log_problem("no rst pulse after finish_end");
  end
  @(posedge clk);
  state <= idle;
  @(negedge clk);
  if (rst !== 1'b0 || ext_cpu_index_out !== '0) begin
    log_mismatch("rst still high or index not retired after the restart");
  end
endtask

task automatic bus_back_pressure();
  logic [30:0]          pos;
  logic [addr_bits-1:0] addr;
  pos = random_position();
  addr = {$random(seed), $random(seed)};
  bring_up({1'b0, pos});
  activate({1'b1, pos});
  @(posedge clk);
  bus_busy <= 1'b1;
  addr_in <= addr;
  ext_cpu_index_in <= {1'b1, pos};
  ext_next_cpu_q <= 1'b1;
  repeat (4) begin
    @(posedge clk);
    @(negedge clk);
    if (ext_cpu_msg !== msg_none || next_state !== 1'b0 || disp_online !== 1'b0) begin
      log_mismatch("grant acted on while bus_busy was high");
    end
    if (cpu_ind_rel !== rel_same) begin
      log_mismatch("relation not tracked while bus_busy was high");
    end
  end
  @(posedge clk);
  bus_busy <= 1'b0;
  @(posedge clk);
  ext_next_cpu_q <= 1'b0;
  @(negedge clk);
  expect_message(msg_start, {1'b1, pos});
  if (base_addr !== addr + addr_bits'(header_space)) begin
    log_mismatch($sformatf("base address %h after the held grant", base_addr));
  end
endtask

`endif

// File: tests/bridge_tb.sv
`default_nettype none

module bridge_tb;
  import bridge_pkg::*;

  localparam int addr_bits = 64;
  localparam int data_bits = 32;
  localparam int header_space = 16;
  localparam int clk_period = 40;
  localparam int num_tests = 6;

  // DUT inputs
  logic                 clk;
  logic                 ext_rst_b;
  cpu_state_t           state;
  logic                 bus_busy;
  logic [addr_bits-1:0] addr_in;
  logic [data_bits-1:0] data_in;
  logic                 read_q;
  logic                 write_q;
  logic                 ext_next_cpu_q;
  logic [data_bits-1:0] ext_cpu_index_in;
  cpu_msg_t             ext_cpu_msg_in;

  // DUT outputs
  logic [addr_bits-1:0] base_addr;
  logic [addr_bits-1:0] base_addr_data;
  cpu_rel_t             cpu_ind_rel;
  logic                 disp_online;
  logic                 next_state;
  logic                 rst;
  logic                 ext_rst_e;
  logic                 ext_next_cpu_e;
  logic                 ext_dispatcher_q;
  cpu_msg_t             ext_cpu_msg;
  logic [data_bits-1:0] ext_cpu_index_out;
  logic                 ext_cpu_index_en;
  logic                 ext_read_q;
  logic                 ext_read_en;
  logic                 ext_write_q;
  logic                 ext_write_en;

  int     mismatches;
  int     problems;
  integer seed;

  bridge_to_outside #(
    .ADDR_W(addr_bits), .DATA_W(data_bits), .THREAD_HEADER_SPACE(header_space)
  ) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // each test fits well inside 200 cycles
  initial begin
    #(num_tests * 200 * clk_period);
    $display("watchdog expired, the tests did not finish in time");
    $display("Result: FAILED");
    $finish;
  end

  task automatic log_mismatch(input string what);
    mismatches++;
    $display("FAILED at time %0t: %s", $time, what);
  endtask

  task automatic log_problem(input string what);
    problems++;
    $display("error at time %0t: %s", $time, what);
  endtask

  // ring position away from 0 so a decrement never wraps
  function automatic logic [30:0] random_position();
    return 31'(($random(seed) & 32'h0000_03ff) + 4);
  endfunction

  `include "bridge_tests.svh"

  initial begin
    mismatches = 0;
    problems = 0;
    seed = 32'hf0b5_f05f;
    ext_rst_b = 1'b1;
    state = idle;
    bus_busy = 1'b0;
    addr_in = '0;
    data_in = '0;
    read_q = 1'b0;
    write_q = 1'b0;
    ext_next_cpu_q = 1'b0;
    ext_cpu_index_in = '0;
    ext_cpu_msg_in = msg_none;

    reset_order();
    thread_start();
    request_forwarding();
    index_renumbering();
    thread_end();
    bus_back_pressure();

    $display("value mismatches: %0d, other errors: %0d", mismatches, problems);
    if (mismatches == 0 && problems == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
source/bridge_pkg.sv
source/reset_sequencer.sv
source/cpu_index_tracker.sv
source/token_dispatch.sv
source/ring_bus_drive.sv
source/bridge_to_outside.sv
tests/bridge_tb.sv

// File: Bender.yml
package:
  name: bridge_to_outside

sources:
  - source/bridge_pkg.sv
  - source/reset_sequencer.sv
  - source/cpu_index_tracker.sv
  - source/token_dispatch.sv
  - source/ring_bus_drive.sv
  - source/bridge_to_outside.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/bridge_tb.sv
